/* bench/CoreTb.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module CoreTb;
    import core_pkg::*;

    localparam int RandomCycles = 400;
    localparam int DirectedCycles = 80;     // idle, pair commit, fill, flush and the drains
    localparam int StimCycles = RandomCycles + DirectedCycles;
    localparam int StallLevel = `ROB_SIZE - `DEC_WIDTH;
    localparam int NumSqN = 1 << `SQN_BITS;

    logic clk;
    logic reset;
    logic en;
    logic inValid[`DEC_WIDTH];
    RegIdx inRegDst[`DEC_WIDTH];
    logic stall;
    logic wbValid;
    SqN wbSqN;
    logic [`DATA_BITS-1:0] wbResult;
    logic branchTaken;
    SqN branchSqN;
    logic comValid[`DEC_WIDTH];
    SqN comSqN[`DEC_WIDTH];
    RegIdx comRegDst[`DEC_WIDTH];
    logic [`DATA_BITS-1:0] comResult[`DEC_WIDTH];

    // scoreboard of every op in flight, indexed by its full sequence number
    logic pendValid[NumSqN];
    RegIdx pendRegDst[NumSqN];
    int pendAccept[NumSqN];                 // edge at which the op was accepted
    logic pendWb[NumSqN];
    int pendWbEdge[NumSqN];
    logic [`DATA_BITS-1:0] pendResult[NumSqN];

    SqN expNext;                            // next number the allocation rule hands out
    SqN expCommit;                          // oldest op not yet committed
    int edgeCount;
    logic anyAccepted;
    logic dualSeen;
    logic stallSeen;
    int flushCount;
    int seed;

    Core uut (
        .clk(clk),
        .reset(reset),
        .en(en),
        .inValid(inValid),
        .inRegDst(inRegDst),
        .stall(stall),
        .wbValid(wbValid),
        .wbSqN(wbSqN),
        .wbResult(wbResult),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .comValid(comValid),
        .comSqN(comSqN),
        .comRegDst(comRegDst),
        .comResult(comResult)
    );

    always #5 clk = ~clk;

    task automatic flagMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("Testbench failed");
        $display("error %s got 0x%0h expected 0x%0h", name, got, expected);
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic stopWithMessage(input string what);
        $display("Testbench failed");
        $display("%s", what);
        $fatal(1, "%s", what);
    endtask

    task automatic checkCommits();
        SqN sq;
        assert (comValid[0] || !comValid[1])
            else stopWithMessage("slot 1 committed while slot 0 did not");
        if (!anyAccepted) begin
            assert (!comValid[0]) else flagMismatch("comValid[0]", comValid[0], 0);
        end
        if (comValid[0] && comValid[1])
            dualSeen = 1'b1;
        for (int k = 0; k < `DEC_WIDTH; k++) begin
            if (comValid[k]) begin
                sq = expCommit;
                assert (comSqN[k] == sq)
                    else flagMismatch($sformatf("comSqN[%0d]", k), comSqN[k], sq);
                assert (pendValid[sq])
                    else stopWithMessage("an op committed that was flushed or never accepted");
                assert (pendWb[sq] && pendWbEdge[sq] < edgeCount)
                    else stopWithMessage("an op committed before its writeback");
                assert (comRegDst[k] == pendRegDst[sq])
                    else flagMismatch($sformatf("comRegDst[%0d]", k), comRegDst[k],
                                      pendRegDst[sq]);
                assert (comResult[k] == pendResult[sq])
                    else flagMismatch($sformatf("comResult[%0d]", k), comResult[k],
                                      pendResult[sq]);
                pendValid[sq] = 1'b0;
                expCommit = expCommit + SqN'(1);
            end
        end
    endtask

    task automatic checkStall();
        SqN outstanding;
        logic expStall;
        outstanding = expNext - expCommit;
        expStall = outstanding > StallLevel;
        assert (stall == expStall) else flagMismatch("stall", stall, expStall);
        if (stall)
            stallSeen = 1'b1;
    endtask

    // outputs are looked at 1 ns after the edge, then the next inputs go out
    task automatic tick();
        @(posedge clk);
        edgeCount++;
        #1;
        checkCommits();
        checkStall();
    endtask

    task automatic clearInputs();
        en = 1'b0;
        for (int k = 0; k < `DEC_WIDTH; k++) begin
            inValid[k] = 1'b0;
            inRegDst[k] = '0;
        end
        wbValid = 1'b0;
        wbSqN = '0;
        wbResult = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
    endtask

    task automatic offerOps(input logic enable, input logic v0, input logic v1);
        SqN outstanding;
        en = enable;
        inValid[0] = v0;
        inValid[1] = v1;
        for (int k = 0; k < `DEC_WIDTH; k++)
            inRegDst[k] = RegIdx'($urandom);
        // ops are taken only while at most ROB_SIZE minus DEC_WIDTH are outstanding
        outstanding = expNext - expCommit;
        if (enable && outstanding <= StallLevel && !branchTaken) begin
            for (int k = 0; k < `DEC_WIDTH; k++) begin
                if (inValid[k]) begin
                    pendValid[expNext] = 1'b1;
                    pendRegDst[expNext] = inRegDst[k];
                    pendAccept[expNext] = edgeCount + 1;
                    pendWb[expNext] = 1'b0;
                    expNext = expNext + SqN'(1);
                    anyAccepted = 1'b1;
                end
            end
        end
    endtask

    task automatic writeBackOp(input SqN sq);
        wbValid = 1'b1;
        wbSqN = sq;
        wbResult = $urandom;
        pendWb[sq] = 1'b1;
        pendWbEdge[sq] = edgeCount + 1;
        pendResult[sq] = wbResult;
    endtask

    // one random op that was accepted at an earlier edge and has no result yet
    task automatic pickWriteBack(input int percent);
        SqN span;
        SqN sq;
        int start;
        logic found;
        span = expNext - expCommit;
        found = 1'b0;
        if (span != 0 && $urandom % 100 < percent) begin
            start = $urandom % span;
            for (int i = 0; i < span && !found; i++) begin
                sq = expCommit + SqN'((start + i) % span);
                if (pendValid[sq] && !pendWb[sq] && pendAccept[sq] <= edgeCount) begin
                    writeBackOp(sq);
                    found = 1'b1;
                end
            end
        end
    endtask

    task automatic flushAt(input SqN branchAt);
        SqN sq;
        branchTaken = 1'b1;
        branchSqN = branchAt;
        sq = branchAt + SqN'(1);
        while (sq != expNext) begin
            pendValid[sq] = 1'b0;
            sq = sq + SqN'(1);
        end
        expNext = branchAt + SqN'(1);
        flushCount++;
    endtask

    task automatic drainAll();
        while (expNext != expCommit) begin
            clearInputs();
            pickWriteBack(100);
            tick();
        end
    endtask

    task automatic randomCycle();
        SqN span;
        span = expNext - expCommit;
        clearInputs();
        if (span != 0 && $urandom % 25 == 0) begin
            flushAt(expCommit + SqN'($urandom % span));
            offerOps(1'b1, 1'b1, 1'b1);     // must be ignored during the flush
        end else begin
            offerOps($urandom % 10 < 6, $urandom % 4 != 0, $urandom % 4 != 0);
            pickWriteBack(75);
        end
        tick();
    endtask

    initial begin
        #(20 * StimCycles * 10);
        stopWithMessage("the run did not finish before the watchdog expired");
    end

    initial begin
        seed = 32'ha442_0c36;
        void'($urandom(seed));
        clk = 1'b0;
        reset = 1'b1;
        clearInputs();
        for (int i = 0; i < NumSqN; i++) begin
            pendValid[i] = 1'b0;
            pendRegDst[i] = '0;
            pendAccept[i] = 0;
            pendWb[i] = 1'b0;
            pendWbEdge[i] = 0;
            pendResult[i] = '0;
        end
        expNext = '0;
        expCommit = '0;
        edgeCount = 0;
        anyAccepted = 1'b0;
        dualSeen = 1'b0;
        stallSeen = 1'b0;
        flushCount = 0;

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) tick();

        // younger op of a pair finishes first so both leave together
        offerOps(1'b1, 1'b1, 1'b1);
        tick();
        clearInputs();
        writeBackOp(expCommit + SqN'(1));
        tick();
        clearInputs();
        writeBackOp(expCommit);
        tick();
        clearInputs();
        repeat (2) tick();

        // no writebacks, the odd count reaches the stall level exactly
        clearInputs();
        offerOps(1'b1, 1'b1, 1'b0);
        tick();
        repeat (9) begin
            clearInputs();
            offerOps(1'b1, 1'b1, 1'b1);
            tick();
        end
        drainAll();

        repeat (3) begin
            clearInputs();
            offerOps(1'b1, 1'b1, 1'b1);
            tick();
        end
        clearInputs();
        flushAt(expCommit + SqN'(2));
        offerOps(1'b1, 1'b1, 1'b1);
        tick();
        clearInputs();
        offerOps(1'b1, 1'b1, 1'b1);         // these get the numbers right after the branch
        tick();
        drainAll();

        repeat (RandomCycles) randomCycle();
        drainAll();

        if (dualSeen && stallSeen && flushCount > 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stopWithMessage("the stimulus never reached a double commit, a stall or a flush");
        end
    end

endmodule

/* include/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// micro-ops dispatched and committed per cycle
`define DEC_WIDTH 2

// reorder buffer depth, a power of two
`define ROB_SIZE 16

// one bit wider than the ROB index so the two halves of the number space
// can be told apart when sequence numbers wrap
`define SQN_BITS 5

// architectural destination register index
`define REG_BITS 5

// result word
`define DATA_BITS 32

`endif

/* project.f */
+incdir+include
verilog/core_pkg.sv
verilog/rob_if.sv
verilog/Rename.sv
verilog/ReorderBuffer.sv
verilog/Retire.sv
verilog/Core.sv
bench/CoreTb.sv

/* verilog/Core.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module Core (
    input logic clk,
    input logic reset,
    input logic en,

    input logic inValid[`DEC_WIDTH],
    input core_pkg::RegIdx inRegDst[`DEC_WIDTH],
    output logic stall,

    input logic wbValid,
    input core_pkg::SqN wbSqN,
    input logic [`DATA_BITS-1:0] wbResult,

    input logic branchTaken,
    input core_pkg::SqN branchSqN,

    output logic comValid[`DEC_WIDTH],
    output core_pkg::SqN comSqN[`DEC_WIDTH],
    output core_pkg::RegIdx comRegDst[`DEC_WIDTH],
    output logic [`DATA_BITS-1:0] comResult[`DEC_WIDTH]
);
    import core_pkg::*;

    RES_UOp wb;
    BranchProv branch;
    SqN curSqN;
    CommitUOp comUOp[`DEC_WIDTH];

    DispatchIf dispatchBus();
    CommitWindowIf windowBus();

    assign wb = '{valid: wbValid, sqN: wbSqN, result: wbResult};
    assign branch = '{taken: branchTaken, sqN: branchSqN};

    always_comb begin
        for (int k = 0; k < `DEC_WIDTH; k++) begin
            comValid[k] = comUOp[k].valid;
            comSqN[k] = comUOp[k].sqN;
            comRegDst[k] = comUOp[k].regDst;
            comResult[k] = comUOp[k].result;
        end
    end

    Rename rename (
        .clk(clk),
        .reset(reset),
        .en(en),
        .inValid(inValid),
        .inRegDst(inRegDst),
        .branch(branch),
        .curSqN(curSqN),            // commit point closes the window
        .stall(stall),
        .dispatch(dispatchBus.src)
    );

    ReorderBuffer rob (
        .clk(clk),
        .reset(reset),
        .dispatch(dispatchBus.dst),
        .wb(wb),
        .branch(branch),
        .window(windowBus.store)
    );

    Retire retire (
        .clk(clk),
        .reset(reset),
        .window(windowBus.reader),
        .curSqN(curSqN),
        .comUOp(comUOp)
    );

endmodule

/* verilog/Rename.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module Rename (
    input logic clk,
    input logic reset,
    input logic en,
    input logic inValid[`DEC_WIDTH],
    input core_pkg::RegIdx inRegDst[`DEC_WIDTH],
    input core_pkg::BranchProv branch,
    input core_pkg::SqN curSqN,
    output logic stall,
    DispatchIf.src dispatch
);
    import core_pkg::*;

    // stall once the fill level comes within DEC_WIDTH of the window limit
    localparam int StallMargin = -`DEC_WIDTH;

    SqN nextSqN;
    SqN allocSqN;
    SqN windowLimit;
    SqN slotSqN[`DEC_WIDTH];
    logic accept[`DEC_WIDTH];
    logic frontEn;

    // one past the youngest sequence number the ROB can hold
    assign windowLimit = curSqN + SqN'(`ROB_SIZE);

    // signed so the comparison survives the wrap of the number space
    assign stall = $signed(nextSqN - windowLimit) > StallMargin;

    // a flush in the same cycle throws away whatever is offered
    assign frontEn = en && !stall && !branch.taken;

    // accepted slots are numbered back to back, slot 0 first
    always_comb begin
        SqN sqN;
        sqN = nextSqN;
        for (int k = 0; k < `DEC_WIDTH; k++) begin
            accept[k] = frontEn && inValid[k];
            slotSqN[k] = sqN;
            if (accept[k])
                sqN = sqN + SqN'(1);
        end
        allocSqN = sqN;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            nextSqN <= '0;
            for (int k = 0; k < `DEC_WIDTH; k++)
                dispatch.uop[k].valid <= 1'b0;
        end else begin
            if (branch.taken)
                nextSqN <= branch.sqN + SqN'(1);    // rewind behind the branch
            else
                nextSqN <= allocSqN;

            // nothing is accepted during a flush, so the registered slots
            // are dropped here and the ROB filters the ones still on the bus
            for (int k = 0; k < `DEC_WIDTH; k++) begin
                dispatch.uop[k].valid <= accept[k];
                dispatch.uop[k].sqN <= slotSqN[k];
                dispatch.uop[k].regDst <= inRegDst[k];
            end
        end
    end

endmodule

/* verilog/ReorderBuffer.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module ReorderBuffer (
    input logic clk,
    input logic reset,
    DispatchIf.dst dispatch,
    input core_pkg::RES_UOp wb,
    input core_pkg::BranchProv branch,
    CommitWindowIf.store window
);
    import core_pkg::*;

    localparam int IdxBits = $clog2(`ROB_SIZE);

    typedef logic [IdxBits-1:0] RobIdx;

    RobEntry entries[`ROB_SIZE];
    RobIdx entryOffset[`ROB_SIZE];
    SqN entrySqN[`ROB_SIZE];
    logic flushEntry[`ROB_SIZE];
    logic flushSlot[`DEC_WIDTH];
    RobIdx headIdx[`DEC_WIDTH];

    // true when sqN lies after branchSqN, modulo the wrap
    function automatic logic isYounger(SqN sqN, SqN branchSqN);
        return $signed(sqN - branchSqN) > 0;
    endfunction

    // the index only holds the low bits, the full number is rebuilt from the head
    always_comb begin
        for (int i = 0; i < `ROB_SIZE; i++) begin
            entryOffset[i] = RobIdx'(i) - window.curSqN[IdxBits-1:0];
            entrySqN[i] = window.curSqN + SqN'(entryOffset[i]);
            flushEntry[i] = branch.taken && isYounger(entrySqN[i], branch.sqN);
        end
    end

    // slots dispatched in the flush cycle may already be on the wrong path
    always_comb begin
        for (int k = 0; k < `DEC_WIDTH; k++)
            flushSlot[k] = branch.taken && isYounger(dispatch.uop[k].sqN, branch.sqN);
    end

    // head entries, hidden from Retire when a flush is killing them
    always_comb begin
        for (int k = 0; k < `DEC_WIDTH; k++) begin
            headIdx[k] = window.curSqN[IdxBits-1:0] + RobIdx'(k);
            window.head[k] = entries[headIdx[k]];
            if (branch.taken && isYounger(window.curSqN + SqN'(k), branch.sqN))
                window.head[k].valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ROB_SIZE; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].done <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `DEC_WIDTH; k++) begin
                if (window.retire[k])
                    entries[headIdx[k]].valid <= 1'b0;
            end

            for (int i = 0; i < `ROB_SIZE; i++) begin
                if (flushEntry[i])
                    entries[i].valid <= 1'b0;
            end

            for (int k = 0; k < `DEC_WIDTH; k++) begin
                if (dispatch.uop[k].valid && !flushSlot[k]) begin
                    entries[dispatch.uop[k].sqN[IdxBits-1:0]].valid <= 1'b1;
                    entries[dispatch.uop[k].sqN[IdxBits-1:0]].done <= 1'b0;
                    entries[dispatch.uop[k].sqN[IdxBits-1:0]].regDst <= dispatch.uop[k].regDst;
                end
            end

            // comes last so a writeback in the dispatch cycle still marks the op done
            if (wb.valid) begin
                entries[wb.sqN[IdxBits-1:0]].done <= 1'b1;
                entries[wb.sqN[IdxBits-1:0]].result <= wb.result;
            end
        end
    end

endmodule

/* verilog/Retire.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module Retire (
    input logic clk,
    input logic reset,
    CommitWindowIf.reader window,
    output core_pkg::SqN curSqN,
    output core_pkg::CommitUOp comUOp[`DEC_WIDTH]
);
    import core_pkg::*;

    SqN headSqN;
    SqN retireCount;
    logic canRetire[`DEC_WIDTH];

    // only an unbroken run of done entries from the head may leave
    always_comb begin
        logic prefix;
        prefix = 1'b1;
        retireCount = '0;
        for (int k = 0; k < `DEC_WIDTH; k++) begin
            prefix = prefix && window.head[k].valid && window.head[k].done;
            canRetire[k] = prefix;
            if (prefix)
                retireCount = retireCount + SqN'(1);
        end
    end

    assign window.retire = canRetire;       // ROB frees these at the edge
    assign window.curSqN = headSqN;
    assign curSqN = headSqN;

    always_ff @(posedge clk) begin
        if (reset) begin
            headSqN <= '0;
            for (int k = 0; k < `DEC_WIDTH; k++)
                comUOp[k].valid <= 1'b0;
        end else begin
            headSqN <= headSqN + retireCount;

            // committed ops are shown for exactly one cycle
            for (int k = 0; k < `DEC_WIDTH; k++) begin
                comUOp[k].valid <= canRetire[k];
                comUOp[k].sqN <= headSqN + SqN'(k);
                comUOp[k].regDst <= window.head[k].regDst;
                comUOp[k].result <= window.head[k].result;
            end
        end
    end

endmodule

/* verilog/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

    typedef logic [`SQN_BITS-1:0] SqN;
    typedef logic [`REG_BITS-1:0] RegIdx;

    typedef struct packed {
        logic valid;
        logic done;                     // writeback seen, entry may commit
        RegIdx regDst;
        logic [`DATA_BITS-1:0] result;
    } RobEntry;

    // renamed op on its way into the ROB
    typedef struct packed {
        logic valid;
        SqN sqN;
        RegIdx regDst;
    } R_UOp;

    typedef struct packed {
        logic valid;
        SqN sqN;
        logic [`DATA_BITS-1:0] result;
    } RES_UOp;

    typedef struct packed {
        logic taken;
        SqN sqN;                        // everything younger than this is discarded
    } BranchProv;

    typedef struct packed {
        logic valid;
        SqN sqN;
        RegIdx regDst;
        logic [`DATA_BITS-1:0] result;
    } CommitUOp;

endpackage

/* verilog/rob_if.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

// renamed slots from Rename into the ROB, one valid strobe per slot
interface DispatchIf;
    import core_pkg::*;

    R_UOp uop[`DEC_WIDTH];

    modport src (
        output uop
    );

    modport dst (
        input uop
    );

endinterface

// the head of the ROB as seen by Retire
interface CommitWindowIf;
    import core_pkg::*;

    SqN curSqN;                         // oldest uncommitted sequence number
    RobEntry head[`DEC_WIDTH];          // entries at curSqN and curSqN + 1
    logic retire[`DEC_WIDTH];           // frees the matching head entry at the edge

    modport reader (
        output curSqN,
        output retire,
        input head
    );

    modport store (
        input curSqN,
        input retire,
        output head
    );

endinterface
